// File: ooo_defs.svh
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// architectural registers
`define N_REG 8

// adder stations sharing the result bus
`define N_FU 3

// adder pipeline depth in cycles
`define FU_LAT 2

// most branches that may be unresolved at once
`define N_B_ENTRY 4

// a producer tag is the index of an adder station
`define TAG_W $clog2(`N_FU)

`endif

// File: isa_pkg.sv
`default_nettype none

`include "ooo_defs.svh"

package isa_pkg;

	localparam int REG_W = $clog2(`N_REG);

	typedef logic [REG_W-1:0] reg_idx_t;

	typedef enum logic [1:0] {
		OP_ADD = 2'd0,
		OP_ACC = 2'd1,
		OP_BR  = 2'd2,
		OP_NOP = 2'd3
	} opcode_e;

	typedef struct packed {
		opcode_e op;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		logic [32-2-3*REG_W-1:0] pad;
	} add_form_t;

	typedef struct packed {
		opcode_e op; // same bits as the ADD view
		reg_idx_t rs;
		logic [32-2-REG_W-1:0] pad;
	} acc_form_t;

	typedef union packed {
		add_form_t add;
		acc_form_t acc;
	} insn_u;

endpackage

`default_nettype wire

// File: ooo_pkg.sv
`default_nettype none

`include "ooo_defs.svh"

package ooo_pkg;

	typedef logic [`TAG_W-1:0] tag_t;

	// valid means a broadcast on the bus, or a value present when used as an operand
	typedef struct packed {
		logic valid;
		tag_t tag;
		logic [31:0] data;
	} cdb_t;

	typedef logic [$clog2(`N_B_ENTRY):0] bcount_t;

	// picks up a missing operand when its producer broadcasts
	function automatic cdb_t snoop(cdb_t opd, cdb_t bus);
		cdb_t o;
		o = opd;
		if (!opd.valid && bus.valid && bus.tag == opd.tag) begin
			o.valid = 1'b1;
			o.data  = bus.data;
		end
		return o;
	endfunction

endpackage

`default_nettype wire

// File: req_if.sv
`timescale 1ns/100ps
`default_nettype none

interface req_if import ooo_pkg::*; ();

	logic valid;
	logic ready;
	cdb_t src_a;
	cdb_t src_b;
	tag_t dst_tag;
	bcount_t b_count; // unresolved branches older than this request

	modport dispatcher (
		output valid, src_a, src_b, dst_tag, b_count,
		input  ready
	);

	modport station (
		input  valid, src_a, src_b, dst_tag, b_count,
		output ready
	);

endinterface

`default_nettype wire

// File: dispatch.sv
`timescale 1ns/100ps
`default_nettype none

`include "ooo_defs.svh"

module dispatch import isa_pkg::*, ooo_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic issue_valid,
	output logic issue_ready,
	input  insn_u issue_word,
	input  logic b_commit,
	input  logic failure,
	input  cdb_t cdb,
	req_if.dispatcher fu_req [`N_FU],
	req_if.dispatcher acc_req
);

	logic [31:0] reg_val [`N_REG];
	logic [`N_REG-1:0] reg_present;
	tag_t reg_tag [`N_REG];
	bcount_t bcnt;

	opcode_e op;
	logic [`N_FU-1:0] fu_ready;
	logic [`N_FU-1:0] fu_sel;
	logic fu_any;
	tag_t fu_idx;
	logic type_ok;
	logic fire;
	cdb_t opd_a;
	cdb_t opd_b;
	cdb_t opd_acc;

	assign op = issue_word.add.op;

	// a value broadcast in this cycle is bypassed into the request
	assign opd_a = snoop('{valid: reg_present[issue_word.add.rs1],
		tag: reg_tag[issue_word.add.rs1], data: reg_val[issue_word.add.rs1]}, cdb);
	assign opd_b = snoop('{valid: reg_present[issue_word.add.rs2],
		tag: reg_tag[issue_word.add.rs2], data: reg_val[issue_word.add.rs2]}, cdb);
	assign opd_acc = snoop('{valid: reg_present[issue_word.acc.rs],
		tag: reg_tag[issue_word.acc.rs], data: reg_val[issue_word.acc.rs]}, cdb);

	// lowest ready adder station wins
	always_comb begin
		fu_sel = '0;
		fu_idx = '0;
		fu_any = 1'b0;
		for (int i = 0; i < `N_FU; i++) begin
			if (fu_ready[i] && !fu_any) begin
				fu_sel[i] = 1'b1;
				fu_idx = tag_t'(i);
				fu_any = 1'b1;
			end
		end
	end

	always_comb begin
		unique case (op)
			OP_ADD: type_ok = fu_any;
			OP_ACC: type_ok = acc_req.ready;
			OP_BR: type_ok = bcnt < bcount_t'(`N_B_ENTRY);
			OP_NOP: type_ok = 1'b1;
		endcase
	end

	assign issue_ready = type_ok && !rst;
	assign fire = issue_valid && issue_ready;

	for (genvar i = 0; i < `N_FU; i++) begin : g_fu_req
		assign fu_ready[i] = fu_req[i].ready;
		assign fu_req[i].valid = fire && op == OP_ADD && fu_sel[i];
		assign fu_req[i].src_a = opd_a;
		assign fu_req[i].src_b = opd_b;
		assign fu_req[i].dst_tag = tag_t'(i);
		assign fu_req[i].b_count = bcnt;
	end

	assign acc_req.valid = fire && op == OP_ACC;
	assign acc_req.src_a = opd_acc;
	assign acc_req.src_b = '0; // the acc station has one operand
	assign acc_req.dst_tag = '0;
	assign acc_req.b_count = bcnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < `N_REG; r++) begin
				reg_val[r] <= '0;
				reg_tag[r] <= '0;
			end
			reg_present <= '1;
			bcnt <= '0;
		end else begin
			for (int r = 0; r < `N_REG; r++) begin
				if (!reg_present[r] && cdb.valid && cdb.tag == reg_tag[r]) begin
					reg_val[r] <= cdb.data;
					reg_present[r] <= 1'b1;
				end
			end
			// renaming the destination overrides a write-back in the same cycle
			if (fire && op == OP_ADD) begin
				reg_present[issue_word.add.rd] <= 1'b0;
				reg_tag[issue_word.add.rd] <= fu_idx;
			end
			if (failure)
				bcnt <= '0;
			else
				bcnt <= bcnt + bcount_t'(fire && op == OP_BR) - bcount_t'(b_commit);
		end
	end

	a_bcnt_range: assert property (@(posedge clk) disable iff (rst)
		bcnt <= bcount_t'(`N_B_ENTRY));

	a_commit_outstanding: assert property (@(posedge clk) disable iff (rst)
		b_commit |-> bcnt != '0);

endmodule

`default_nettype wire

// File: fu_station.sv
`timescale 1ns/100ps
`default_nettype none

`include "ooo_defs.svh"

module fu_station import ooo_pkg::*; #(
	parameter int ID = 0
) (
	input  logic clk,
	input  logic rst,
	req_if.station req,
	input  cdb_t cdb,
	input  logic grant,
	output logic bus_req,
	output cdb_t result
);

	logic busy;
	logic fired; // sum already sent down the pipeline
	cdb_t opd_a;
	cdb_t opd_b;
	logic take;
	logic launch;
	logic [`FU_LAT-1:0] pv;
	logic [31:0] pd [`FU_LAT];
	logic [`FU_LAT-1:0] chain_v;
	logic [31:0] chain_d [`FU_LAT];

	assign req.ready = !busy;
	assign take = req.valid && req.ready;
	assign launch = busy && !fired && opd_a.valid && opd_b.valid;

	// input side of each pipeline stage
	always_comb begin
		chain_v[0] = launch;
		chain_d[0] = opd_a.data + opd_b.data;
		for (int i = 1; i < `FU_LAT; i++) begin
			chain_v[i] = pv[i-1];
			chain_d[i] = pd[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			fired <= 1'b0;
			pv <= '0;
		end else begin
			if (take) begin
				busy <= 1'b1;
				fired <= 1'b0;
			end else if (bus_req && grant) begin
				busy <= 1'b0;
			end
			if (launch)
				fired <= 1'b1;
			for (int i = 0; i < `FU_LAT-1; i++)
				pv[i] <= chain_v[i];
			pv[`FU_LAT-1] <= chain_v[`FU_LAT-1] || (pv[`FU_LAT-1] && !grant); // wait for the bus
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			opd_a <= req.src_a;
			opd_b <= req.src_b;
		end else begin
			opd_a <= snoop(opd_a, cdb);
			opd_b <= snoop(opd_b, cdb);
		end
		for (int i = 0; i < `FU_LAT; i++) begin
			if (chain_v[i])
				pd[i] <= chain_d[i];
		end
	end

	assign bus_req = pv[`FU_LAT-1];
	assign result = '{valid: bus_req, tag: tag_t'(ID), data: pd[`FU_LAT-1]};

	a_result_hold: assert property (@(posedge clk) disable iff (rst)
		bus_req && !grant |=> bus_req && $stable(result));

endmodule

`default_nettype wire

// File: cdb_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "ooo_defs.svh"

module cdb_arbiter import ooo_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic [`N_FU-1:0] bus_req,
	output logic [`N_FU-1:0] grant
);

	tag_t ptr; // station with top priority
	int win;
	logic found;

	always_comb begin
		int idx;
		grant = '0;
		win = 0;
		found = 1'b0;
		for (int k = 0; k < `N_FU; k++) begin
			idx = (int'(ptr) + k) % `N_FU;
			if (bus_req[idx] && !found) begin
				grant[idx] = 1'b1;
				win = idx;
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			ptr <= '0;
		else if (found)
			ptr <= tag_t'((win + 1) % `N_FU); // winner drops to lowest priority
	end

	a_grant_legal: assert property (@(posedge clk) disable iff (rst)
		$onehot0(grant) && (grant & ~bus_req) == '0);

endmodule

`default_nettype wire

// File: acc.sv
`timescale 1ns/100ps
`default_nettype none

module acc import ooo_pkg::*; (
	input  logic clk,
	input  logic rst,
	req_if.station issue_req,
	input  cdb_t cdb,
	input  logic b_commit,
	input  logic failure,
	output logic acc_valid,
	input  logic acc_ready,
	output logic [31:0] acc_data
);

	logic e_valid;
	cdb_t opd;
	bcount_t e_bcnt; // branches still ahead of this entry
	logic confirmed;
	logic handover;
	logic take;
	bcount_t new_bcnt;

	assign confirmed = e_valid && e_bcnt == '0;
	assign acc_valid = confirmed && opd.valid;
	assign acc_data = opd.data;
	assign handover = acc_valid && acc_ready;

	// a new entry can replace the one leaving in the same cycle
	assign issue_req.ready = !e_valid || handover;
	assign take = issue_req.valid && issue_req.ready;

	// a commit in the issue cycle retires a branch older than the new entry
	assign new_bcnt = issue_req.b_count == '0 ? '0 : issue_req.b_count - bcount_t'(b_commit);

	always_ff @(posedge clk) begin
		if (rst) begin
			e_valid <= 1'b0;
		end else if (take) begin
			e_valid <= !(failure && issue_req.b_count != '0);
		end else if (handover || (failure && !confirmed)) begin
			e_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			opd <= issue_req.src_a;
			e_bcnt <= new_bcnt;
		end else begin
			opd <= snoop(opd, cdb);
			if (e_bcnt != '0)
				e_bcnt <= e_bcnt - bcount_t'(b_commit);
		end
	end

	// a confirmed entry ignores failure, so the offer cannot be withdrawn
	a_offer_hold: assert property (@(posedge clk) disable iff (rst)
		acc_valid && !acc_ready |=> acc_valid && $stable(acc_data));

endmodule

`default_nettype wire

// File: fp_acc_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "ooo_defs.svh"

module fp_acc_core import ooo_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic issue_valid,
	output logic issue_ready,
	input  logic [31:0] issue_word,
	input  logic b_commit,
	input  logic failure,
	output logic acc_valid,
	input  logic acc_ready,
	output logic [31:0] acc_data
);

	req_if fu_req [`N_FU] ();
	req_if acc_req ();

	logic [`N_FU-1:0] bus_req;
	logic [`N_FU-1:0] grant;
	cdb_t fu_result [`N_FU];
	cdb_t cdb;

	dispatch u_dispatch (
		.clk(clk),
		.rst(rst),
		.issue_valid(issue_valid),
		.issue_ready(issue_ready),
		.issue_word(issue_word),
		.b_commit(b_commit),
		.failure(failure),
		.cdb(cdb),
		.fu_req(fu_req),
		.acc_req(acc_req)
	);

	for (genvar i = 0; i < `N_FU; i++) begin : g_fu
		fu_station #(.ID(i)) u_fu_station (
			.clk(clk),
			.rst(rst),
			.req(fu_req[i]),
			.cdb(cdb),
			.grant(grant[i]),
			.bus_req(bus_req[i]),
			.result(fu_result[i])
		);
	end

	cdb_arbiter u_cdb_arbiter (
		.clk(clk),
		.rst(rst),
		.bus_req(bus_req),
		.grant(grant)
	);

	acc u_acc (
		.clk(clk),
		.rst(rst),
		.issue_req(acc_req),
		.cdb(cdb),
		.b_commit(b_commit),
		.failure(failure),
		.acc_valid(acc_valid),
		.acc_ready(acc_ready),
		.acc_data(acc_data)
	);

	// grants are one-hot so at most one station drives the bus
	always_comb begin
		cdb = '0;
		for (int i = 0; i < `N_FU; i++) begin
			if (grant[i])
				cdb = fu_result[i];
		end
	end

endmodule

`default_nettype wire

// File: tb_fp_acc_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "ooo_defs.svh"

module tb_fp_acc_core;

	localparam int PERIOD = 40;
	localparam int N_ISSUE = 400;
	localparam int RST_CYCLES = 10;
	localparam int DRAIN_MAX = 400;
	localparam int RW = $clog2(`N_REG);
	localparam logic [1:0] OPC_ADD = 2'd0;
	localparam logic [1:0] OPC_ACC = 2'd1;
	localparam logic [1:0] OPC_BR = 2'd2;
	localparam logic [1:0] OPC_NOP = 2'd3;

	logic clk;
	logic rst;
	logic issue_valid;
	logic issue_ready;
	logic [31:0] issue_word;
	logic b_commit;
	logic failure;
	logic acc_valid;
	logic acc_ready;
	logic [31:0] acc_data;

	integer seed;
	logic [31:0] prog [N_ISSUE];
	int pc;
	logic [31:0] model_reg [`N_REG];
	int model_bcnt;
	logic [31:0] exp_val [$]; // expected ACC values in program order
	int exp_cnt [$]; // branches each one still waits on
	logic hold_prev;
	logic [31:0] hold_data;
	int n_xfer;
	int err_data;
	int err_order;
	int err_hold;
	int err_misc;
	int drain;

	fp_acc_core u_fp_acc_core (
		.clk(clk),
		.rst(rst),
		.issue_valid(issue_valid),
		.issue_ready(issue_ready),
		.issue_word(issue_word),
		.b_commit(b_commit),
		.failure(failure),
		.acc_valid(acc_valid),
		.acc_ready(acc_ready),
		.acc_data(acc_data)
	);

	always #(PERIOD/2) clk = ~clk;

	// opcode in the top two bits, register fields below it, random padding
	task automatic build_program();
		logic [31:0] rnd;
		logic [31:0] fields;
		logic [1:0] opc;
		for (int i = 0; i < N_ISSUE; i++) begin
			rnd = $random(seed);
			fields = $random(seed);
			if (rnd[7:0] % 20 < 9)
				opc = OPC_ADD;
			else if (rnd[7:0] % 20 < 16)
				opc = OPC_ACC;
			else if (rnd[7:0] % 20 < 19)
				opc = OPC_BR;
			else
				opc = OPC_NOP;
			prog[i] = {opc, fields[29:0]};
		end
	endtask

	// model update and checks for the cycle that ends at this edge
	task automatic observe();
		logic [1:0] opc;
		int rd;
		int rs1;
		int rs2;
		if (hold_prev) begin
			if (acc_valid !== 1'b1) begin
				err_hold++;
				$display("ERR acc_valid dropped before acc_ready got %h exp 1 at %0t",
					acc_valid, $time);
			end else if (acc_data !== hold_data) begin
				err_hold++;
				$display("ERR acc_data changed under back-pressure got %h exp %h",
					acc_data, hold_data);
			end
		end
		hold_prev = acc_valid && !acc_ready;
		hold_data = acc_data;
		if (acc_valid && acc_ready) begin
			n_xfer++;
			if (exp_val.size() == 0) begin
				err_order++;
				$display("an ACC value came out with none expected at %0t", $time);
			end else begin
				if (exp_cnt[0] != 0) begin
					err_order++;
					$display("an ACC value came out with %0d branches unresolved at %0t",
						exp_cnt[0], $time);
				end
				if (acc_data !== exp_val[0]) begin
					err_data++;
					$display("ERR acc_data got %h exp %h", acc_data, exp_val[0]);
				end
				exp_val.delete(0);
				exp_cnt.delete(0);
			end
		end
		if (issue_valid && issue_ready) begin
			opc = issue_word[31:30];
			rd = int'(issue_word[29 -: RW]);
			rs1 = int'(issue_word[29-RW -: RW]);
			rs2 = int'(issue_word[29-2*RW -: RW]);
			case (opc)
				OPC_ADD: model_reg[rd] = model_reg[rs1] + model_reg[rs2];
				OPC_ACC: begin
					exp_val.push_back(model_reg[rd]); // the ACC source sits where ADD keeps rd
					exp_cnt.push_back(model_bcnt);
				end
				OPC_BR: begin
					if (model_bcnt >= `N_B_ENTRY) begin
						err_misc++;
						$display("a branch was accepted with %0d already outstanding", model_bcnt);
					end
					model_bcnt++;
				end
				default: ;
			endcase
			pc++;
		end
		// failure sees the counts from before any commit
		if (failure) begin
			for (int i = exp_cnt.size() - 1; i >= 0; i--) begin
				if (exp_cnt[i] != 0) begin
					exp_val.delete(i);
					exp_cnt.delete(i);
				end
			end
			model_bcnt = 0;
		end else if (b_commit) begin
			for (int i = 0; i < exp_cnt.size(); i++) begin
				if (exp_cnt[i] != 0)
					exp_cnt[i]--;
			end
			model_bcnt--;
		end
	endtask

	task automatic drive_random();
		logic [31:0] rnd;
		logic commit;
		rnd = $random(seed);
		if (!(issue_valid && !issue_ready)) begin // a refused word stays on offer
			if (pc < N_ISSUE && rnd[3:0] < 4'd12) begin
				issue_valid <= 1'b1;
				issue_word <= prog[pc];
			end else begin
				issue_valid <= 1'b0;
			end
		end
		commit = model_bcnt > 0 && rnd[7:4] < 4'd5;
		b_commit <= commit;
		failure <= !commit && rnd[13:8] == 6'd0;
		acc_ready <= rnd[19:16] < 4'd11;
	endtask

	task automatic drive_drain();
		issue_valid <= 1'b0;
		failure <= 1'b0;
		acc_ready <= 1'b1;
		b_commit <= model_bcnt > 0;
	endtask

	initial begin
		seed = 32'hf3044a0f;
		clk = 1'b0;
		rst = 1'b1;
		issue_valid = 1'b0;
		issue_word = '0;
		b_commit = 1'b0;
		failure = 1'b0;
		acc_ready = 1'b0;
		pc = 0;
		model_bcnt = 0;
		hold_prev = 1'b0;
		hold_data = '0;
		n_xfer = 0;
		err_data = 0;
		err_order = 0;
		err_hold = 0;
		err_misc = 0;
		for (int r = 0; r < `N_REG; r++)
			model_reg[r] = '0;
		build_program();

		repeat (RST_CYCLES) begin
			@(posedge clk);
			if (issue_ready !== 1'b0) begin
				err_misc++;
				$display("ERR issue_ready got %h exp 0 during reset at %0t", issue_ready, $time);
			end
		end
		rst <= 1'b0;
		@(posedge clk);
		if (acc_valid !== 1'b0) begin
			err_misc++;
			$display("ERR acc_valid got %h exp 0 at the first edge after reset", acc_valid);
		end
		observe();
		drive_random();
		while (pc < N_ISSUE) begin
			@(posedge clk);
			observe();
			drive_random();
		end

		// commit everything left and take every offer
		drain = 0;
		while (drain < 4 ||
			((exp_val.size() != 0 || model_bcnt != 0) && drain < DRAIN_MAX)) begin
			@(posedge clk);
			observe();
			drive_drain();
			drain++;
		end
		if (exp_val.size() != 0) begin
			err_misc++;
			$display("%0d expected ACC values never came out", exp_val.size());
		end
		if (n_xfer == 0) begin
			err_misc++;
			$display("no ACC value came out during the whole run");
		end

		$display("transfers %0d, errors data %0d, order %0d, hold %0d, other %0d",
			n_xfer, err_data, err_order, err_hold, err_misc);
		if (err_data + err_order + err_hold + err_misc == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		#(N_ISSUE * 40 * PERIOD);
		$display("timeout after %0d ns with %0d of %0d words issued",
			N_ISSUE * 40 * PERIOD, pc, N_ISSUE);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: fp_acc_core.f
+incdir+.
isa_pkg.sv
ooo_pkg.sv
req_if.sv
dispatch.sv
fu_station.sv
cdb_arbiter.sv
acc.sv
fp_acc_core.sv
tb_fp_acc_core.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_fp_acc_core
FILELIST = fp_acc_core.f
PASS_MSG = ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
